//--- mem_subsys.f
rtl/mem_bus_pkg.sv
rtl/bus_port_tracker.sv
rtl/bus_arbiter.sv
rtl/sram_slave.sv
rtl/mem_subsys.sv
verif/mem_bus_checker.sv
verif/tb_mem_subsys.sv

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  port_state_e port_state [N_MASTERS],

    input  bus_req_t    mst_req [N_MASTERS],
    output bus_rsp_t    mst_rsp [N_MASTERS],

    output bus_req_t    slv_req,
    input  bus_rsp_t    slv_rsp
);

    logic [GRANT_W-1:0] grant;
    logic [GRANT_W-1:0] grant_next;
    logic               grant_free;

    // the grant may only move once its owner has nothing pending
    assign grant_free = (port_state[grant] == PORT_FREE);

    // fixed priority, the lowest waiting index wins
    always_comb begin
        grant_next = grant;
        if (grant_free) begin
            for (int i = N_MASTERS - 1; i >= 0; i--) begin
                if (port_state[i] == PORT_WAIT) begin
                    grant_next = GRANT_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
        end else begin
            grant <= grant_next;
        end
    end

    // whole bundles are steered, the slave only ever sees one master
    always_comb begin
        slv_req = mst_req[grant];
    end

    // responses reach the granted master alone, everyone else sees zeros
    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            if (GRANT_W'(i) == grant) begin
                mst_rsp[i] = slv_rsp;
            end else begin
                mst_rsp[i] = '0;
            end
        end
    end

endmodule

//--- rtl/bus_port_tracker.sv
`timescale 1ns/1ps

module bus_port_tracker
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  bus_req_t    req,
    input  bus_rsp_t    rsp,
    output port_state_e state
);

    logic ar_hs;
    logic aw_hs;
    logic r_done;
    logic b_done;
    logic requesting;

    // rsp is already routed, so a master without the grant never sees a ready
    assign ar_hs = req.arvalid && rsp.arready;
    assign aw_hs = req.awvalid && req.wvalid && rsp.awready && rsp.wready;

    assign r_done = rsp.rvalid && req.rready;
    assign b_done = rsp.bvalid && req.bready;

    // a write only counts as a request once both address and data are offered
    assign requesting = req.arvalid || (req.awvalid && req.wvalid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= PORT_FREE;
        end else if (ar_hs || aw_hs) begin
            state <= PORT_BUSY;
        end else if (requesting) begin
            state <= PORT_WAIT;
        end else if (r_done || b_done) begin
            state <= PORT_FREE;
        end
    end

endmodule

//--- rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam int N_MASTERS = 2;
    localparam int GRANT_W   = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

    // SRAM geometry, byte addressed with word granularity
    localparam int MEM_DEPTH = 256;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    // cycles from address handshake to the response valid
    localparam int READ_LATENCY  = 2;
    localparam int WRITE_LATENCY = 1;
    localparam int MAX_LATENCY   =
        (READ_LATENCY > WRITE_LATENCY) ? READ_LATENCY : WRITE_LATENCY;
    localparam int LAT_W         = $clog2(MAX_LATENCY + 1);

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef enum logic [1:0] {
        PORT_FREE = 2'b00,
        PORT_WAIT = 2'b01,
        PORT_BUSY = 2'b10
    } port_state_e;

    typedef enum logic [1:0] {
        SLV_IDLE  = 2'b00,
        SLV_READ  = 2'b01,
        SLV_WRITE = 2'b10
    } slave_state_e;

    // master to slave
    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic              rready;
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              wvalid;
        logic              bready;
    } bus_req_t;

    // slave to master
    typedef struct packed {
        logic              arready;
        logic [DATA_W-1:0] rdata;
        resp_e             rresp;
        logic              rvalid;
        logic              awready;
        logic              wready;
        resp_e             bresp;
        logic              bvalid;
    } bus_rsp_t;

endpackage

//--- rtl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // master 0 is instruction fetch, master 1 is load/store
    input  bus_req_t mst_req [N_MASTERS],
    output bus_rsp_t mst_rsp [N_MASTERS]
);

    port_state_e port_state [N_MASTERS];

    bus_req_t    slv_req;
    bus_rsp_t    slv_rsp;

    // each tracker sees its own request and the response routed back to it
    for (genvar i = 0; i < N_MASTERS; i++) begin : g_tracker
        bus_port_tracker u_tracker (
            .clk   (clk),
            .rst   (rst),
            .req   (mst_req[i]),
            .rsp   (mst_rsp[i]),
            .state (port_state[i])
        );
    end

    bus_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .port_state (port_state),
        .mst_req    (mst_req),
        .mst_rsp    (mst_rsp),
        .slv_req    (slv_req),
        .slv_rsp    (slv_rsp)
    );

    sram_slave u_sram (
        .clk (clk),
        .rst (rst),
        .req (slv_req),
        .rsp (slv_rsp)
    );

endmodule

//--- rtl/sram_slave.sv
`timescale 1ns/1ps

module sram_slave
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t req,
    output bus_rsp_t rsp
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    slave_state_e      state;
    logic [LAT_W-1:0]  lat_cnt;

    logic [DATA_W-1:0] rdata_q;
    resp_e             resp_q;

    logic              rd_hs;
    logic              wr_hs;
    logic              rd_ok;
    logic              wr_ok;
    logic              rvalid;
    logic              bvalid;

    // anything beyond the last word answers with an error
    function automatic logic addr_ok(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:MEM_AW+2] == '0;
    endfunction

    function automatic logic [MEM_AW-1:0] word_idx(input logic [ADDR_W-1:0] addr);
        return addr[MEM_AW+1:2];
    endfunction

    // reads win over a write offered in the same cycle
    assign rd_hs = (state == SLV_IDLE) && req.arvalid;
    assign wr_hs = (state == SLV_IDLE) && !req.arvalid && req.awvalid && req.wvalid;

    assign rd_ok = addr_ok(req.araddr);
    assign wr_ok = addr_ok(req.awaddr);

    // the counter reaches zero exactly when the response becomes due
    assign rvalid = (state == SLV_READ) && (lat_cnt == '0);
    assign bvalid = (state == SLV_WRITE) && (lat_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= SLV_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                SLV_IDLE: begin
                    if (rd_hs) begin
                        state   <= SLV_READ;
                        lat_cnt <= LAT_W'(READ_LATENCY - 1);
                    end else if (wr_hs) begin
                        state   <= SLV_WRITE;
                        lat_cnt <= LAT_W'(WRITE_LATENCY - 1);
                    end
                end
                SLV_READ: begin
                    if (lat_cnt != '0) begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end else if (req.rready) begin
                        state <= SLV_IDLE;
                    end
                end
                SLV_WRITE: begin
                    if (lat_cnt != '0) begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end else if (req.bready) begin
                        state <= SLV_IDLE;
                    end
                end
                default: begin
                    state <= SLV_IDLE;
                end
            endcase
        end
    end

    // storage starts out cleared, only strobed bytes of in-range words change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_hs && wr_ok) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req.wstrb[b]) begin
                    mem[word_idx(req.awaddr)][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // only one transaction is open at a time, so one response register serves both
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rd_ok ? mem[word_idx(req.araddr)] : '0;
            resp_q  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end else if (wr_hs) begin
            resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.arready = rd_hs;
        rsp.awready = wr_hs;
        rsp.wready  = wr_hs;
        rsp.rvalid  = rvalid;
        rsp.rdata   = rvalid ? rdata_q : '0;
        rsp.rresp   = rvalid ? resp_q : RESP_OKAY;
        rsp.bvalid  = bvalid;
        rsp.bresp   = bvalid ? resp_q : RESP_OKAY;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the memory subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_mem_subsys \
    --Mdir "$BUILD_DIR" \
    -o sim_mem_subsys \
    -f mem_subsys.f

# keep running past checker errors so the summary line is printed
"$BUILD_DIR/sim_mem_subsys" +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
else
    exit 1
fi

//--- verif/mem_bus_checker.sv
`timescale 1ns/1ps

module mem_bus_checker
    import mem_bus_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic [GRANT_W-1:0] grant,
    input port_state_e        port_state [N_MASTERS],
    input bus_req_t           mst_req [N_MASTERS],
    input bus_rsp_t           mst_rsp [N_MASTERS],
    input bus_req_t           slv_req
);

    int                   fail_cnt = 0;
    logic [N_MASTERS-1:0] rsp_active;
    logic                 stray_rsp;

    // a master sees a response when any field of its bundle is set
    always_comb begin
        stray_rsp = 1'b0;
        for (int i = 0; i < N_MASTERS; i++) begin
            rsp_active[i] = (mst_rsp[i] != '0);
            if (rsp_active[i] && (GRANT_W'(i) != grant)) begin
                stray_rsp = 1'b1;
            end
        end
    end

    one_response_a: assert property (@(posedge clk) disable iff (rst)
        $countones(rsp_active) <= 1)
        else begin
            $error("more than one master sees a response");
            fail_cnt++;
        end

    granted_response_a: assert property (@(posedge clk) disable iff (rst) !stray_rsp)
        else begin
            $error("a master without the grant sees a response");
            fail_cnt++;
        end

    // the owner of a transaction in flight keeps the bus
    grant_hold_a: assert property (@(posedge clk) disable iff (rst)
        (port_state[grant] == PORT_BUSY) |=> $stable(grant))
        else begin
            $error("grant moved away from a busy master");
            fail_cnt++;
        end

    slave_route_a: assert property (@(posedge clk) disable iff (rst)
        slv_req == mst_req[grant])
        else begin
            $error("slave request differs from the granted master request");
            fail_cnt++;
        end

endmodule

//--- verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
    import mem_bus_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 1;
    localparam int SEED        = 6976;
    localparam int N_BASIC     = 16;
    localparam int N_PARTIAL   = 8;
    localparam int N_RANDOM    = 40;
    localparam int N_OOB       = 4;
    localparam int TOTAL_TXN   = 2 * N_BASIC + 3 * N_PARTIAL + N_MASTERS * N_RANDOM
                                 + 2 * N_OOB + MEM_DEPTH;
    // worst case per transaction with the other master holding the slave
    localparam int CYC_PER_TXN = 40;

    logic       clk;
    logic       rst;
    bus_req_t   mst_req [N_MASTERS];
    bus_rsp_t   mst_rsp [N_MASTERS];

    logic [7:0] ref_mem [MEM_DEPTH * 4];
    int         cyc;
    int         err_cnt;
    int         txn_cnt;
    int         chk_fail;

    mem_subsys u_dut (
        .clk     (clk),
        .rst     (rst),
        .mst_req (mst_req),
        .mst_rsp (mst_rsp)
    );

    bind bus_arbiter mem_bus_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .grant      (grant),
        .port_state (port_state),
        .mst_req    (mst_req),
        .mst_rsp    (mst_rsp),
        .slv_req    (slv_req)
    );

    always begin
        #(CLK_PERIOD / 2);
        clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic flag_mismatch(input string msg);
        err_cnt++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    function automatic logic [ADDR_W-1:0] word_addr(input int w);
        return ADDR_W'(w) << 2;
    endfunction

    function automatic logic addr_in_range(input logic [ADDR_W-1:0] addr);
        return (addr >> 2) < MEM_DEPTH;
    endfunction

    function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] w;
        int                base;
        base = int'(addr >> 2) * 4;
        for (int b = 0; b < STRB_W; b++) begin
            w[8*b +: 8] = ref_mem[base + b];
        end
        return w;
    endfunction

    task automatic ref_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
        int base;
        base = int'(addr >> 2) * 4;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                ref_mem[base + b] = data[8*b +: 8];
            end
        end
    endtask

    // valid, data and response of the read or write response channel
    function automatic logic [DATA_W+2:0] rsp_view(input int m, input logic is_read);
        if (is_read) begin
            return {mst_rsp[m].rvalid, mst_rsp[m].rdata, mst_rsp[m].rresp};
        end
        return {mst_rsp[m].bvalid, {DATA_W{1'b0}}, mst_rsp[m].bresp};
    endfunction

    // requests start on even cycles and never right after a completion, so the
    // granted master cannot start while another master has just begun waiting
    task automatic wait_start(input int gap);
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        while (cyc[0]) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic accept_response(input int m, input logic is_read);
        logic [DATA_W+2:0] held;
        int                rdy_dly;
        held    = rsp_view(m, is_read);
        rdy_dly = $urandom_range(0, 4);
        repeat (rdy_dly) begin
            @(posedge clk);
            #DRIVE_DLY;
            @(negedge clk);
            assert (rsp_view(m, is_read) == held)
                else flag_mismatch($sformatf("master %0d response changed before ready", m));
        end
        @(posedge clk);
        #DRIVE_DLY;
        mst_req[m].rready = is_read;
        mst_req[m].bready = !is_read;
        @(negedge clk);
        assert (rsp_view(m, is_read) == held)
            else flag_mismatch($sformatf("master %0d response changed at ready", m));
        @(posedge clk);
        #DRIVE_DLY;
        mst_req[m].rready = 1'b0;
        mst_req[m].bready = 1'b0;
    endtask

    task automatic read_txn(input int m, input logic [ADDR_W-1:0] addr, input int gap);
        logic [DATA_W-1:0] exp_data;
        resp_e             exp_resp;
        int                hs_cyc;
        wait_start(gap);
        mst_req[m].araddr  = addr;
        mst_req[m].arvalid = 1'b1;
        @(negedge clk);
        while (!mst_rsp[m].arready) @(negedge clk);
        hs_cyc   = cyc;
        exp_resp = addr_in_range(addr) ? RESP_OKAY : RESP_SLVERR;
        exp_data = addr_in_range(addr) ? ref_word(addr) : '0;
        @(posedge clk);
        #DRIVE_DLY;
        mst_req[m].arvalid = 1'b0;
        @(negedge clk);
        while (!mst_rsp[m].rvalid) @(negedge clk);
        assert (cyc - hs_cyc == READ_LATENCY)
            else flag_mismatch($sformatf("read latency %0d cycles", cyc - hs_cyc));
        assert (mst_rsp[m].rdata == exp_data && mst_rsp[m].rresp == exp_resp)
            else flag_mismatch($sformatf(
                "master %0d read 0x%08h got 0x%08h/%0d, expected 0x%08h/%0d",
                m, addr, mst_rsp[m].rdata, mst_rsp[m].rresp, exp_data, exp_resp));
        accept_response(m, 1'b1);
        txn_cnt++;
    endtask

    task automatic write_txn(input int m, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                             input int gap);
        resp_e exp_resp;
        int    hs_cyc;
        wait_start(gap);
        mst_req[m].awaddr  = addr;
        mst_req[m].wdata   = data;
        mst_req[m].wstrb   = strb;
        mst_req[m].awvalid = 1'b1;
        mst_req[m].wvalid  = 1'b1;
        @(negedge clk);
        while (!(mst_rsp[m].awready && mst_rsp[m].wready)) begin
            assert (mst_rsp[m].awready == mst_rsp[m].wready)
                else flag_mismatch($sformatf("master %0d awready and wready differ", m));
            @(negedge clk);
        end
        hs_cyc   = cyc;
        exp_resp = addr_in_range(addr) ? RESP_OKAY : RESP_SLVERR;
        if (addr_in_range(addr)) begin
            ref_write(addr, data, strb);
        end
        @(posedge clk);
        #DRIVE_DLY;
        mst_req[m].awvalid = 1'b0;
        mst_req[m].wvalid  = 1'b0;
        @(negedge clk);
        while (!mst_rsp[m].bvalid) @(negedge clk);
        assert (cyc - hs_cyc == WRITE_LATENCY)
            else flag_mismatch($sformatf("write latency %0d cycles", cyc - hs_cyc));
        assert (mst_rsp[m].bresp == exp_resp)
            else flag_mismatch($sformatf("master %0d write 0x%08h got resp %0d, expected %0d",
                                         m, addr, mst_rsp[m].bresp, exp_resp));
        accept_response(m, 1'b0);
        txn_cnt++;
    endtask

    task automatic basic_write_read();
        logic [ADDR_W-1:0] addr_q [N_BASIC];
        for (int i = 0; i < N_BASIC; i++) begin
            addr_q[i] = word_addr($urandom_range(0, MEM_DEPTH - 1));
            write_txn(1, addr_q[i], $urandom(), '1, $urandom_range(1, 3));
        end
        for (int i = 0; i < N_BASIC; i++) begin
            read_txn(1, addr_q[i], $urandom_range(1, 3));
        end
    endtask

    task automatic partial_strobe_writes();
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < N_PARTIAL; i++) begin
            addr = word_addr($urandom_range(0, MEM_DEPTH - 1));
            write_txn(0, addr, $urandom(), '1, 1);
            write_txn(0, addr, $urandom(), STRB_W'($urandom_range(1, 14)), 1);
            read_txn(0, addr, 1);
        end
    endtask

    task automatic master_traffic(input int m);
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < N_RANDOM; i++) begin
            addr = word_addr($urandom_range(0, MEM_DEPTH - 1));
            if ($urandom_range(0, 1) == 0) begin
                read_txn(m, addr, $urandom_range(1, 4));
            end else begin
                write_txn(m, addr, $urandom(), STRB_W'($urandom_range(1, 15)),
                          $urandom_range(1, 4));
            end
        end
    endtask

    task automatic out_of_range_access();
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < N_OOB; i++) begin
            // the last one sits at the very top of the address space
            addr = (i == N_OOB - 1) ? 32'hffff_fffc
                                    : word_addr(MEM_DEPTH + $urandom_range(0, 4095));
            write_txn(1, addr, $urandom(), '1, 1);
            read_txn(1, addr, 1);
        end
    endtask

    task automatic final_readback();
        for (int w = 0; w < MEM_DEPTH; w++) begin
            read_txn(0, word_addr(w), 1);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk     = 1'b0;
        rst     = 1'b1;
        cyc     = 0;
        err_cnt = 0;
        txn_cnt = 0;
        for (int i = 0; i < N_MASTERS; i++) begin
            mst_req[i] = '0;
        end
        for (int i = 0; i < MEM_DEPTH * 4; i++) begin
            ref_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < N_MASTERS; i++) begin
            assert (mst_rsp[i] == '0)
                else flag_mismatch($sformatf("master %0d response not idle after reset", i));
        end
        basic_write_read();
        partial_strobe_writes();
        fork
            master_traffic(0);
            master_traffic(1);
        join
        out_of_range_access();
        final_readback();
        chk_fail = u_dut.u_arbiter.u_checker.fail_cnt;
        $display("%0d transactions, %0d mismatches, %0d assertion failures",
                 txn_cnt, err_cnt, chk_fail);
        if (err_cnt == 0 && chk_fail == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_TXN * CYC_PER_TXN + 200));
        $display("timeout: %0d of %0d transactions finished", txn_cnt, TOTAL_TXN);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
